// File: build.f
logic/lsu_pkg.sv
logic/lsu_store_align.sv
logic/lsu_load_extend.sv
logic/lsu_axi_master.sv
logic/lsu_sram_slave.sv
logic/lsu_top.sv
verif/lsu_sva.sv
verif/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator, then look for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f build.f \
    -o lsu_sim > build.log 2>&1 \
    && ./obj_dir/lsu_sim > sim.log 2>&1 \
    && grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: verif/lsu_tb.sv
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int          CLK_PERIOD     = 100;
    localparam int          DRIVE_DLY      = 10;
    localparam int          RESET_CYCLES   = 8;
    localparam logic [31:0] MEM_BASE       = 32'h8000_0000;
    localparam int unsigned MEM_WORDS      = 256;
    localparam int          MAX_REQUESTS   = 160;
    localparam int          CYCLES_PER_REQ = 8;
    localparam int          TIMEOUT        =
        (RESET_CYCLES + MAX_REQUESTS * CYCLES_PER_REQ + 40) * CLK_PERIOD;

    logic      clk;
    logic      rst;
    logic      req_valid;
    logic      req_ready;
    lsu_req_t  req;
    logic      resp_valid;
    logic      resp_ready;
    lsu_resp_t resp;

    logic [31:0] model [MEM_WORDS]; // expected memory contents.
    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;

    lsu_top #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32, 22, 2, 1.
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic int unsigned word_index(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - MEM_BASE;
        return int'(off >> 2);
    endfunction

    function automatic lsu_req_t make_req(input lsu_op_e op, input lsu_size_e size,
                                          input logic [31:0] addr, input logic [31:0] wdata,
                                          input logic uns);
        lsu_req_t r;
        r.addr        = addr;
        r.wdata       = wdata;
        r.op          = op;
        r.size        = size;
        r.is_unsigned = uns;
        return r;
    endfunction

    // bytes k of the store data land in byte lanes offset + k.
    task automatic model_store(input logic [31:0] addr, input lsu_size_e size,
                               input logic [31:0] wdata);
        int unsigned idx;
        int unsigned off;
        int unsigned nbytes;
        idx    = word_index(addr);
        off    = addr[1:0];
        nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        for (int k = 0; k < nbytes; k++) begin
            model[idx][8*(off+k) +: 8] = wdata[8*k +: 8];
        end
    endtask

    function automatic logic [31:0] load_expect(input logic [31:0] addr,
                                                input lsu_size_e size, input logic uns);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = model[word_index(addr)];
        case (addr[1:0])
            2'd0: b = word[7:0];
            2'd1: b = word[15:8];
            2'd2: b = word[23:16];
            default: b = word[31:24];
        endcase
        h = addr[1] ? word[31:16] : word[15:0];
        if (size == SIZE_BYTE) return uns ? {24'h0, b} : {{24{b[7]}}, b};
        if (size == SIZE_HALF) return uns ? {16'h0, h} : {{16{h[15]}}, h};
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic send_request(input lsu_req_t rq);
        req       = rq;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        @(posedge clk); // handshake on this edge.
        #DRIVE_DLY;
        req_valid = 1'b0;
    endtask

    // lat counts cycles from the request handshake to resp_valid.
    task automatic wait_result(output lsu_resp_t rs, output int lat);
        lat = 1;
        while (!resp_valid) begin
            @(posedge clk);
            #DRIVE_DLY;
            lat++;
        end
        rs = resp;
    endtask

    task automatic do_request(input lsu_req_t rq, output lsu_resp_t rs, output int lat);
        send_request(rq);
        wait_result(rs, lat);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic store_check(input logic [31:0] addr, input lsu_size_e size,
                               input logic [31:0] wdata);
        lsu_resp_t rs;
        int        lat;
        do_request(make_req(LSU_STORE, size, addr, wdata, 1'b0), rs, lat);
        model_store(addr, size, wdata);
        check_value("resp.addr", rs.addr, addr);
        check_value("resp.fault", rs.fault, 1'b0);
        check_value("store latency", lat, 3);
    endtask

    task automatic load_check(input logic [31:0] addr, input lsu_size_e size, input logic uns);
        lsu_resp_t rs;
        int        lat;
        do_request(make_req(LSU_LOAD, size, addr, 32'h0, uns), rs, lat);
        check_value("resp.data", rs.data, load_expect(addr, size, uns));
        check_value("resp.addr", rs.addr, addr);
        check_value("resp.fault", rs.fault, 1'b0);
        check_value("load latency", lat, 3);
    endtask

    task automatic word_roundtrip();
        for (int i = 0; i < 4; i++) begin
            store_check(MEM_BASE + 32'(i * 85 * 4), SIZE_WORD, take_bits(32));
        end
        for (int i = 0; i < 4; i++) begin
            load_check(MEM_BASE + 32'(i * 85 * 4), SIZE_WORD, 1'b0);
        end
    endtask

    task automatic subword_merge();
        logic [31:0] a;
        logic [31:0] a2;
        a  = MEM_BASE + 32'hA0;
        a2 = MEM_BASE + 32'hA4;
        store_check(a, SIZE_WORD, 32'h1122_3344);
        for (int k = 0; k < 4; k++) begin
            store_check(a + 32'(k), SIZE_BYTE, 32'hA5A5_A500 | 32'(8'h7C + 8'h11 * k));
        end
        load_check(a, SIZE_WORD, 1'b0);
        store_check(a2, SIZE_WORD, 32'h0);
        store_check(a2, SIZE_HALF, 32'h1234_8001);
        store_check(a2 + 32'd2, SIZE_HALF, 32'h5678_7FFE);
        load_check(a2, SIZE_WORD, 1'b0);
        for (int u = 0; u < 2; u++) begin
            for (int k = 0; k < 4; k++) begin
                load_check(a + 32'(k), SIZE_BYTE, u[0]);
                load_check(a2 + 32'(k), SIZE_BYTE, u[0]);
            end
            for (int k = 0; k < 4; k += 2) begin
                load_check(a + 32'(k), SIZE_HALF, u[0]);
                load_check(a2 + 32'(k), SIZE_HALF, u[0]);
            end
        end
    endtask

    task automatic no_access();
        lsu_resp_t rs;
        int        lat;
        do_request(make_req(LSU_NONE, SIZE_WORD, 32'h1234_5678, 32'hFFFF_FFFF, 1'b0), rs, lat);
        check_value("resp.data", rs.data, 32'h1234_5678);
        check_value("resp.fault", rs.fault, 1'b0);
        check_value("no-access latency", lat, 1);
    endtask

    // both stores alias words 0 and 255 if the window check is missing.
    task automatic out_of_window();
        lsu_resp_t rs;
        int        lat;
        logic [31:0] above;
        above = MEM_BASE + MEM_WORDS * 4;
        do_request(make_req(LSU_STORE, SIZE_WORD, above, 32'hBAD0_BAD0, 1'b0), rs, lat);
        check_value("resp.fault", rs.fault, 1'b1);
        check_value("resp.addr", rs.addr, above);
        do_request(make_req(LSU_STORE, SIZE_WORD, MEM_BASE - 4, 32'hBAD1_BAD1, 1'b0), rs, lat);
        check_value("resp.fault", rs.fault, 1'b1);
        do_request(make_req(LSU_LOAD, SIZE_WORD, above, 32'h0, 1'b0), rs, lat);
        check_value("resp.fault", rs.fault, 1'b1);
        check_value("resp.data", rs.data, 32'h0);
        load_check(MEM_BASE, SIZE_WORD, 1'b0);
        load_check(MEM_BASE + 32'd1020, SIZE_WORD, 1'b0);
    endtask

    task automatic back_pressure();
        lsu_resp_t rs;
        lsu_resp_t held;
        int        lat;
        logic [31:0] a;
        a = MEM_BASE + 32'd340;
        resp_ready = 1'b0;
        send_request(make_req(LSU_LOAD, SIZE_WORD, a, 32'h0, 1'b0));
        wait_result(held, lat);
        check_value("resp.data", held.data, load_expect(a, SIZE_WORD, 1'b0));
        repeat (5) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_value("resp_valid", resp_valid, 1'b1);
            check_value("req_ready", req_ready, 1'b0);
            check_value("resp.addr", resp.addr, held.addr);
            check_value("resp.data", resp.data, held.data);
            check_value("resp.fault", resp.fault, held.fault);
        end
        resp_ready = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        check_value("resp_valid", resp_valid, 1'b0);
        check_value("req_ready", req_ready, 1'b1);
        do_request(make_req(LSU_NONE, SIZE_WORD, 32'h0BAD_F00D, 32'h0, 1'b0), rs, lat);
        check_value("resp.data", rs.data, 32'h0BAD_F00D);
    endtask

    task automatic random_traffic();
        logic [31:0] addr;
        logic [1:0]  off;
        lsu_size_e   size;
        logic [1:0]  sz_bits;
        logic        is_store;
        logic [31:0] data;
        logic        uns;
        for (int i = 0; i < 16; i++) begin
            store_check(MEM_BASE + 32'((64 + i) * 4), SIZE_WORD, take_bits(32));
        end
        for (int n = 0; n < 80; n++) begin
            addr    = MEM_BASE + ((32'd64 + take_bits(4)) << 2);
            sz_bits = 2'(take_bits(2));
            size    = (sz_bits == 2'd0) ? SIZE_BYTE : (sz_bits == 2'd1) ? SIZE_HALF : SIZE_WORD;
            if (size == SIZE_BYTE) off = 2'(take_bits(2));
            else if (size == SIZE_HALF) off = {1'(take_bits(1)), 1'b0};
            else off = 2'd0;
            addr[1:0] = off;
            is_store  = 1'(take_bits(1));
            data      = take_bits(32);
            uns       = 1'(take_bits(1));
            if (is_store) store_check(addr, size, data);
            else load_check(addr, size, uns);
        end
    endtask

    initial begin
        #TIMEOUT;
        $display("timeout: the DUT stopped answering before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        lfsr       = 32'h73ef;
        n_checks   = 0;
        n_errors   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        check_value("req_ready", req_ready, 1'b1);
        check_value("resp_valid", resp_valid, 1'b0);
        word_roundtrip();
        subword_merge();
        no_access();
        out_of_window();
        back_pressure();
        random_traffic();
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/lsu_sva.sv
`default_nettype none

module lsu_sva import lsu_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      aw_valid,
    input logic      aw_ready,
    input axi_addr_t aw,
    input logic      w_valid,
    input logic      w_ready,
    input axi_w_t    w,
    input logic      ar_valid,
    input logic      ar_ready,
    input axi_addr_t ar,
    input logic      resp_valid,
    input logic      resp_ready,
    input lsu_resp_t resp
);

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw changed before its handshake.");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w changed before its handshake.");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar changed before its handshake.");

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("resp changed under back-pressure.");

    // one transaction at a time.
    one_dir: assert property (@(posedge clk) disable iff (rst) !(aw_valid && ar_valid))
        else $error("aw_valid and ar_valid high together.");

    reset_idle: assert property (@(posedge clk) $fell(rst) |-> !resp_valid)
        else $error("resp_valid high right after reset.");

endmodule

bind lsu_axi_master lsu_sva i_sva (
    .clk        (clk),
    .rst        (rst),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .aw         (aw),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w          (w),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar         (ar),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
);

`default_nettype wire

// File: logic/lsu_top.sv
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter logic [31:0] MEM_BASE  = 32'h8000_0000,
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  lsu_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output lsu_resp_t resp
);

    logic      aw_valid, aw_ready;
    logic      w_valid, w_ready;
    logic      b_valid, b_ready;
    logic      ar_valid, ar_ready;
    logic      r_valid, r_ready;
    axi_addr_t aw;
    axi_addr_t ar;
    axi_w_t    w;
    axi_b_t    b;
    axi_r_t    r;

    lsu_axi_master i_master (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw         (aw),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w          (w),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .b          (b),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r          (r)
    );

    lsu_sram_slave #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) i_sram (
        .clk      (clk),
        .rst      (rst),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

endmodule

`default_nettype wire

// File: logic/lsu_sram_slave.sv
`default_nettype none

module lsu_sram_slave import lsu_pkg::*; #(
    parameter logic [31:0] MEM_BASE  = 32'h8000_0000,
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      aw_valid,
    output logic      aw_ready,
    input  axi_addr_t aw,
    input  logic      w_valid,
    output logic      w_ready,
    input  axi_w_t    w,
    output logic      b_valid,
    input  logic      b_ready,
    output axi_b_t    b,
    input  logic      ar_valid,
    output logic      ar_ready,
    input  axi_addr_t ar,
    output logic      r_valid,
    input  logic      r_ready,
    output axi_r_t    r
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] aw_off;
    logic [31:0] ar_off;
    logic        aw_hit;
    logic        ar_hit;
    logic        wr_fire;
    logic        rd_fire;

    assign aw_off = aw.addr - MEM_BASE;
    assign ar_off = ar.addr - MEM_BASE;
    assign aw_hit = (aw.addr >= MEM_BASE) && (aw_off[31:2] < MEM_WORDS);
    assign ar_hit = (ar.addr >= MEM_BASE) && (ar_off[31:2] < MEM_WORDS);

    // address and data are taken together, one write at a time.
    assign aw_ready = aw_valid && w_valid && !b_valid;
    assign w_ready  = aw_ready;
    assign ar_ready = !r_valid;
    assign wr_fire  = aw_valid && aw_ready;
    assign rd_fire  = ar_valid && ar_ready;

    always_ff @(posedge clk) begin
        if (wr_fire && aw_hit) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) mem[aw_off[IDX_W+1:2]][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (b_valid && b_ready) b_valid <= 1'b0;
            if (wr_fire) b_valid <= 1'b1;
            if (r_valid && r_ready) r_valid <= 1'b0;
            if (rd_fire) r_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) b.resp <= aw_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        if (rd_fire) begin
            r.data <= ar_hit ? mem[ar_off[IDX_W+1:2]] : 32'h0; // outside reads zero.
            r.resp <= ar_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_axi_master.sv
`default_nettype none

module lsu_axi_master import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  logic      req_valid,
    output logic      req_ready,
    input  lsu_req_t  req,

    output logic      resp_valid,
    input  logic      resp_ready,
    output lsu_resp_t resp,

    output logic      aw_valid,
    input  logic      aw_ready,
    output axi_addr_t aw,
    output logic      w_valid,
    input  logic      w_ready,
    output axi_w_t    w,
    input  logic      b_valid,
    output logic      b_ready,
    input  axi_b_t    b,
    output logic      ar_valid,
    input  logic      ar_ready,
    output axi_addr_t ar,
    input  logic      r_valid,
    output logic      r_ready,
    input  axi_r_t    r
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WRITE = 2'd1,
        READ  = 2'd2,
        DONE  = 2'd3
    } state_e;

    state_e      state;
    lsu_req_t    req_q;
    logic        req_fire;
    logic [31:0] st_data;
    logic [3:0]  st_strb;
    logic [31:0] ld_data;

    assign req_ready = (state == IDLE);
    assign req_fire  = req_valid && req_ready;

    // store lanes come from the incoming request.
    lsu_store_align i_store_align (
        .addr_low (req.addr[1:0]),
        .size     (req.size),
        .wdata    (req.wdata),
        .data     (st_data),
        .strb     (st_strb)
    );

    // load extension uses the registered request.
    lsu_load_extend i_load_extend (
        .addr_low    (req_q.addr[1:0]),
        .size        (req_q.size),
        .is_unsigned (req_q.is_unsigned),
        .rdata       (r.data),
        .data        (ld_data)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            ar_valid   <= 1'b0;
            b_ready    <= 1'b0;
            r_ready    <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_fire) begin
                        case (req.op)
                            LSU_STORE: begin
                                aw_valid <= 1'b1;
                                w_valid  <= 1'b1;
                                b_ready  <= 1'b1;
                                state    <= WRITE;
                            end
                            LSU_LOAD: begin
                                ar_valid <= 1'b1;
                                r_ready  <= 1'b1;
                                state    <= READ;
                            end
                            default: begin
                                resp_valid <= 1'b1; // nothing to access.
                                state      <= DONE;
                            end
                        endcase
                    end
                end
                WRITE: begin
                    if (aw_valid && aw_ready) aw_valid <= 1'b0;
                    if (w_valid && w_ready) w_valid <= 1'b0;
                    if (b_valid && b_ready) begin
                        b_ready    <= 1'b0;
                        resp_valid <= 1'b1;
                        state      <= DONE;
                    end
                end
                READ: begin
                    if (ar_valid && ar_ready) ar_valid <= 1'b0;
                    if (r_valid && r_ready) begin
                        r_ready    <= 1'b0;
                        resp_valid <= 1'b1;
                        state      <= DONE;
                    end
                end
                default: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        state      <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q      <= req;
            aw.addr    <= req.addr;
            ar.addr    <= req.addr;
            w.data     <= st_data;
            w.strb     <= st_strb;
            resp.addr  <= req.addr;
            resp.data  <= (req.op == LSU_NONE) ? req.addr : 32'h0;
            resp.fault <= 1'b0;
        end
        if (state == WRITE && b_valid && b_ready) begin
            resp.fault <= (b.resp != AXI_RESP_OKAY);
        end
        if (state == READ && r_valid && r_ready) begin
            resp.data  <= ld_data;
            resp.fault <= (r.resp != AXI_RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_load_extend.sv
`default_nettype none

module lsu_load_extend import lsu_pkg::*; (
    input  logic [1:0]  addr_low,
    input  lsu_size_e   size,
    input  logic        is_unsigned,
    input  logic [31:0] rdata,
    output logic [31:0] data
);

    logic [31:0] shifted;

    always_comb begin
        shifted = rdata >> {addr_low, 3'b000};
        case (size)
            SIZE_BYTE: begin
                data = {{24{~is_unsigned & shifted[7]}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                data = {{16{~is_unsigned & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                data = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/lsu_store_align.sv
`default_nettype none

module lsu_store_align import lsu_pkg::*; (
    input  logic [1:0]  addr_low,
    input  lsu_size_e   size,
    input  logic [31:0] wdata,
    output logic [31:0] data,
    output logic [3:0]  strb
);

    always_comb begin
        data = wdata << {addr_low, 3'b000}; // move to the byte lane.
        case (size)
            SIZE_BYTE: begin
                strb = 4'b0001 << addr_low;
            end
            SIZE_HALF: begin
                strb = 4'b0011 << addr_low;
            end
            default: begin
                strb = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef enum logic [1:0] {
        LSU_NONE  = 2'd0,
        LSU_LOAD  = 2'd1,
        LSU_STORE = 2'd2
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } lsu_size_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;       // store data, low bits.
        lsu_op_e     op;
        lsu_size_e   size;
        logic        is_unsigned;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        fault;
    } lsu_resp_t;

    // shared by aw and ar.
    typedef struct packed {
        logic [31:0] addr;
    } axi_addr_t;

    // single beat, always last.
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
